// File: Makefile
# Verilator build for the PAM4 FIR filter

VERILATOR ?= verilator
TOP ?= pamFilterTb
RTL_TOP ?= pamFilterTop
FILELIST ?= pamFilter.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Test OK
VFLAGS ?= --binary --timing --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing -Wall --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: adderTree/adderTreeStage.sv
`timescale 1ns/1ps
`default_nettype none

module adderTreeStage #(
	parameter int IN_COUNT = 2,
	localparam int OUT_COUNT = (IN_COUNT + 1) / 2
) (
	input logic sys_clk,
	input logic reset,
	input logic samClkEn,
	input pamFilterPkg::sample_t sumIn [IN_COUNT],
	output pamFilterPkg::sample_t sumOut [OUT_COUNT]
);

	import pamFilterPkg::*;

	localparam int PAIR_COUNT = IN_COUNT / 2;

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			for (int k = 0; k < OUT_COUNT; k++) begin
				sumOut[k] <= '0;
			end
		end else if (samClkEn) begin
			for (int k = 0; k < PAIR_COUNT; k++) begin
				sumOut[k] <= wrapAdd(sumIn[2*k], sumIn[2*k+1]);
			end
			// odd leftover rides through to the next level
			if (IN_COUNT % 2 == 1) begin
				sumOut[OUT_COUNT-1] <= sumIn[IN_COUNT-1];
			end
		end
	end

endmodule

`default_nettype wire

// File: adderTree/foldedPreAdder.sv
`timescale 1ns/1ps
`default_nettype none

module foldedPreAdder (
	input logic sys_clk,
	input logic reset,
	input logic samClkEn,
	input pamFilterPkg::sample_t products [pamFilterPkg::TAP_COUNT],
	output pamFilterPkg::sample_t foldSum [pamFilterPkg::FOLD_COUNT]
);

	import pamFilterPkg::*;

	// pair k with its mirror, sums wrap at 18 bits
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			for (int k = 0; k < FOLD_COUNT; k++) begin
				foldSum[k] <= '0;
			end
		end else if (samClkEn) begin
			for (int k = 0; k < CENTER_TAP; k++) begin
				foldSum[k] <= wrapAdd(products[k], products[TAP_COUNT-1-k]);
			end
			// centre tap has no partner
			foldSum[CENTER_TAP] <= products[CENTER_TAP];
		end
	end

endmodule

`default_nettype wire

// File: common/filterCoefs.svh
`ifndef FILTER_COEFS_SVH
`define FILTER_COEFS_SVH

// half of the symmetric 21 tap response, index 10 is the centre
// one row per level, last row is the probe column
localparam sample_t COEF_TABLE [COEF_COLS][HALF_TAPS] = '{
	// -3 level
	'{-18'sd2969, -18'sd2844, -18'sd702, 18'sd2577, 18'sd5119, 18'sd4886,
		18'sd739, -18'sd6815, -18'sd15613, -18'sd22645, -18'sd25327},
	// -1 level
	'{-18'sd990, -18'sd948, -18'sd234, 18'sd859, 18'sd1706, 18'sd1629,
		18'sd246, -18'sd2272, -18'sd5204, -18'sd7548, -18'sd8442},
	// +1 level
	'{18'sd990, 18'sd948, 18'sd234, -18'sd859, -18'sd1706, -18'sd1629,
		-18'sd246, 18'sd2272, 18'sd5204, 18'sd7548, 18'sd8442},
	// +3 level
	'{18'sd2969, 18'sd2844, 18'sd702, -18'sd2577, -18'sd5119, -18'sd4886,
		-18'sd739, 18'sd6815, 18'sd15613, 18'sd22645, 18'sd25327},
	// probe, raw tap values
	'{18'sd7918, 18'sd7584, 18'sd1872, -18'sd6872, -18'sd13651, -18'sd13029,
		-18'sd1970, 18'sd18174, 18'sd41636, 18'sd60388, 18'sd67540}
};

`endif

// File: common/pamFilterPkg.sv
`default_nettype none

package pamFilterPkg;

	// datapath width, shared by samples, products and all partial sums
	localparam int SAMPLE_W = 18;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// filter geometry
	localparam int TAP_COUNT = 21;
	localparam int HALF_TAPS = (TAP_COUNT + 1) / 2;
	localparam int CENTER_TAP = HALF_TAPS - 1;

	// mapper decision, column order matches the coefficient table
	typedef enum logic [2:0] {
		LVL_NEG3,
		LVL_NEG1,
		LVL_POS1,
		LVL_POS3,
		LVL_PROBE,
		LVL_NONE
	} levelSel_t;

	localparam int LEVEL_COUNT = 4;
	localparam int COEF_COLS = LEVEL_COUNT + 1;

	// symmetric PAM4 level centres
	localparam sample_t LEVEL_CENTER [LEVEL_COUNT] = '{
		-18'sd98303,
		-18'sd32768,
		18'sd32768,
		18'sd98303
	};

	// strict window, a match lies inside centre +/- (tol - 1)
	localparam int LEVEL_TOL = 10;

	// all-ones positive value reads the probe column
	localparam sample_t PROBE_VALUE = 18'sd131071;

	`include "filterCoefs.svh"

	// fold output: mirror pair sums plus the centre tap
	localparam int FOLD_COUNT = HALF_TAPS;

	// input count of each tree stage, the last entry is the final sum
	localparam int TREE_SIZES [5] = '{
		FOLD_COUNT,
		(FOLD_COUNT + 1) / 2,
		((FOLD_COUNT + 1) / 2 + 1) / 2,
		2,
		1
	};

	// wrapped sum of two samples
	function automatic sample_t wrapAdd(sample_t a, sample_t b);
		sample_t s;
		s = a + b;
		return s;
	endfunction

endpackage

`default_nettype wire

// File: hdl/pamFilterTop.sv
`timescale 1ns/1ps
`default_nettype none

module pamFilterTop (
	input logic sys_clk,
	input logic reset,
	input logic samClkEn,
	input pamFilterPkg::sample_t xIn,
	output pamFilterPkg::sample_t y
);

	import pamFilterPkg::*;

	sample_t taps [TAP_COUNT];
	sample_t products [TAP_COUNT];
	sample_t foldSum [FOLD_COUNT];
	sample_t treeL1 [TREE_SIZES[1]];
	sample_t treeL2 [TREE_SIZES[2]];
	sample_t treeL3 [TREE_SIZES[3]];
	sample_t treeL4 [TREE_SIZES[4]];

	tapDelayLine delayLine0 (
		.sys_clk (sys_clk),
		.reset (reset),
		.samClkEn (samClkEn),
		.xIn (xIn),
		.taps (taps)
	);

	// one level slicer per tap
	for (genvar i = 0; i < TAP_COUNT; i++) begin : genMapper
		symbolTapMapper #(
			.TAP_INDEX (i)
		) mapper (
			.sample (taps[i]),
			.product (products[i])
		);
	end

	foldedPreAdder fold0 (
		.sys_clk (sys_clk),
		.reset (reset),
		.samClkEn (samClkEn),
		.products (products),
		.foldSum (foldSum)
	);

	// 11 -> 6 -> 3 -> 2 -> 1
	adderTreeStage #(.IN_COUNT (TREE_SIZES[0])) stage1 (
		.sys_clk (sys_clk),
		.reset (reset),
		.samClkEn (samClkEn),
		.sumIn (foldSum),
		.sumOut (treeL1)
	);

	adderTreeStage #(.IN_COUNT (TREE_SIZES[1])) stage2 (
		.sys_clk (sys_clk),
		.reset (reset),
		.samClkEn (samClkEn),
		.sumIn (treeL1),
		.sumOut (treeL2)
	);

	adderTreeStage #(.IN_COUNT (TREE_SIZES[2])) stage3 (
		.sys_clk (sys_clk),
		.reset (reset),
		.samClkEn (samClkEn),
		.sumIn (treeL2),
		.sumOut (treeL3)
	);

	adderTreeStage #(.IN_COUNT (TREE_SIZES[3])) stage4 (
		.sys_clk (sys_clk),
		.reset (reset),
		.samClkEn (samClkEn),
		.sumIn (treeL3),
		.sumOut (treeL4)
	);

	// output register, sixth strobe after the sample enters
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			y <= '0;
		end else if (samClkEn) begin
			y <= treeL4[0];
		end
	end

endmodule

`default_nettype wire

// File: hdl/symbolTapMapper.sv
`timescale 1ns/1ps
`default_nettype none

module symbolTapMapper #(
	parameter int TAP_INDEX = 0
) (
	input pamFilterPkg::sample_t sample,
	output pamFilterPkg::sample_t product
);

	import pamFilterPkg::*;

	// mirror taps share one coefficient
	localparam int MIRROR_INDEX = TAP_COUNT - 1 - TAP_INDEX;
	localparam int FOLD_IDX = (TAP_INDEX < MIRROR_INDEX) ? TAP_INDEX : MIRROR_INDEX;

	levelSel_t level;

	// strict window check, done in 32 bits so the bounds never wrap
	function automatic logic inWindow(sample_t s, sample_t centre);
		int lo;
		int hi;
		lo = int'(centre) - LEVEL_TOL;
		hi = int'(centre) + LEVEL_TOL;
		return (int'(s) > lo) && (int'(s) < hi);
	endfunction

	always_comb begin
		level = LVL_NONE;
		if (sample == PROBE_VALUE) begin
			level = LVL_PROBE;
		end else begin
			// walk down so the lowest matching level wins
			for (int k = LEVEL_COUNT - 1; k >= 0; k--) begin
				if (inWindow(sample, LEVEL_CENTER[k])) begin
					level = levelSel_t'(k);
				end
			end
		end
	end

	// table lookup stands in for the multiply
	always_comb begin
		if (level == LVL_NONE) begin
			product = '0;
		end else begin
			product = COEF_TABLE[level][FOLD_IDX];
		end
	end

endmodule

`default_nettype wire

// File: hdl/tapDelayLine.sv
`timescale 1ns/1ps
`default_nettype none

module tapDelayLine (
	input logic sys_clk,
	input logic reset,
	input logic samClkEn,
	input pamFilterPkg::sample_t xIn,
	output pamFilterPkg::sample_t taps [pamFilterPkg::TAP_COUNT]
);

	import pamFilterPkg::*;

	// newest sample in tap 0, oldest in the last tap
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			for (int i = 0; i < TAP_COUNT; i++) begin
				taps[i] <= '0;
			end
		end else if (samClkEn) begin
			taps[0] <= xIn;
			for (int i = 1; i < TAP_COUNT; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

endmodule

`default_nettype wire

// File: pamFilter.f
+incdir+common
+incdir+verification
common/pamFilterPkg.sv
hdl/tapDelayLine.sv
hdl/symbolTapMapper.sv
adderTree/foldedPreAdder.sv
adderTree/adderTreeStage.sv
hdl/pamFilterTop.sv
verification/pamFilterTb.sv

// File: verification/pamFilterModel.svh
`ifndef PAM_FILTER_MODEL_SVH
`define PAM_FILTER_MODEL_SVH

// strobes from a sample entering tap 0 until it shows in y
localparam int PIPE_LATENCY = 6;

// samples presented on strobes, newest first
sample_t history[$];

// table column for a sample, -1 when it sits on no level
function automatic int sliceLevel(sample_t x);
	int col;
	int d;
	col = -1;
	if (x == PROBE_VALUE) begin
		col = int'(LVL_PROBE);
	end else begin
		for (int k = 0; k < LEVEL_COUNT; k++) begin
			d = int'(x) - int'(LEVEL_CENTER[k]);
			if (col < 0 && d > -LEVEL_TOL && d < LEVEL_TOL) begin
				col = k;
			end
		end
	end
	return col;
endfunction

// symmetric response, so tap i and tap 20 - i share one entry
function automatic sample_t tapCoef(int col, int tap);
	int fold;
	sample_t c;
	fold = (tap < TAP_COUNT - 1 - tap) ? tap : TAP_COUNT - 1 - tap;
	if (col < 0 || tap < 0 || tap >= TAP_COUNT) begin
		c = '0;
	end else begin
		c = COEF_TABLE[col][fold];
	end
	return c;
endfunction

function automatic void recordSample(sample_t x);
	history.push_front(x);
	if (history.size() > TAP_COUNT + PIPE_LATENCY) begin
		void'(history.pop_back());
	end
endfunction

// wrapped 18-bit convolution over the samples that have reached y
function automatic sample_t expectedY();
	int acc;
	acc = 0;
	for (int i = 0; i < TAP_COUNT; i++) begin
		if (PIPE_LATENCY + i < history.size()) begin
			acc += int'(tapCoef(sliceLevel(history[PIPE_LATENCY + i]), i));
		end
	end
	return acc[SAMPLE_W-1:0];
endfunction

`endif

// File: verification/pamFilterTb.sv
`timescale 1ns/1ps
`default_nettype none

module pamFilterTb;

	import pamFilterPkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int STROBE_SPACING = 3;
	localparam int IMPULSE_LEN = TAP_COUNT + 6;
	localparam int HOLD_CYCLES = 40;
	localparam int RANDOM_STROBES = 200;
	// hold cycles counted as if each were a strobe
	localparam int TOTAL_STROBES = 30 + 17 * IMPULSE_LEN + 29 + HOLD_CYCLES + RANDOM_STROBES;
	localparam int CYCLE_LIMIT = 3 * TOTAL_STROBES * STROBE_SPACING;

	logic sys_clk;
	logic reset;
	logic samClkEn;
	sample_t xIn;
	sample_t y;

	integer seed;
	int errorCount;
	int checkCount;
	int testErrors;
	int cycleCount = 0;

	`include "pamFilterModel.svh"

	pamFilterTop dut0 (
		.sys_clk (sys_clk),
		.reset (reset),
		.samClkEn (samClkEn),
		.xIn (xIn),
		.y (y)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("run stopped, no finish after %0d cycles", cycleCount);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic checkY(sample_t expected);
		checkCount++;
		if (y !== expected) begin
			errorCount++;
			$display("** Error at time %0t: y expected %0d, got %0d", $time, expected, y);
		end
	endtask

	// one strobe every third cycle, y read at the falling edge after it
	task automatic driveStrobe(sample_t x);
		repeat (STROBE_SPACING - 1) @(posedge sys_clk);
		xIn <= x;
		samClkEn <= 1'b1;
		@(posedge sys_clk);
		samClkEn <= 1'b0;
		recordSample(x);
		@(negedge sys_clk);
	endtask

	task automatic strobeAndCheck(sample_t x);
		driveStrobe(x);
		checkY(expectedY());
	endtask

	task automatic reportTest(string name);
		$display("%s: %s, %0d errors", name, (errorCount == testErrors) ? "pass" : "fail",
			errorCount - testErrors);
		testErrors = errorCount;
	endtask

	// lone sample then zeros, y walks through the column in tap order
	task automatic impulseRun(sample_t x, int col);
		driveStrobe(x);
		checkY(tapCoef(col, -PIPE_LATENCY));
		for (int k = 1; k < IMPULSE_LEN; k++) begin
			driveStrobe('0);
			checkY(tapCoef(col, k - PIPE_LATENCY));
		end
	endtask

	task automatic testReset();
		@(negedge sys_clk);
		checkY('0);
		for (int n = 0; n < 30; n++) begin
			driveStrobe('0);
			checkY('0);
		end
		reportTest("reset");
	endtask

	task automatic testProbeImpulse();
		impulseRun(PROBE_VALUE, int'(LVL_PROBE));
		reportTest("probe impulse");
	endtask

	task automatic testLevelWindows();
		int c;
		for (int lvl = 0; lvl < LEVEL_COUNT; lvl++) begin
			c = int'(LEVEL_CENTER[lvl]);
			impulseRun(sample_t'(c + LEVEL_TOL - 1), lvl);
			impulseRun(sample_t'(c - LEVEL_TOL + 1), lvl);
			impulseRun(sample_t'(c + LEVEL_TOL), -1);
			impulseRun(sample_t'(c - LEVEL_TOL), -1);
		end
		reportTest("level windows");
	endtask

	task automatic testHold();
		sample_t held;
		strobeAndCheck(PROBE_VALUE);
		for (int n = 0; n < 8; n++) begin
			strobeAndCheck(LEVEL_CENTER[n % LEVEL_COUNT]);
		end
		held = expectedY();
		// input keeps moving, nothing may follow it
		repeat (HOLD_CYCLES) begin
			@(posedge sys_clk);
			xIn <= sample_t'($random(seed));
			@(negedge sys_clk);
			checkY(held);
		end
		for (int n = 0; n < 20; n++) begin
			strobeAndCheck(LEVEL_CENTER[(n + 1) % LEVEL_COUNT]);
		end
		reportTest("hold");
	endtask

	task automatic testRandomStream();
		int runLeft;
		int lvl;
		int jitter;
		sample_t x;
		runLeft = 0;
		for (int n = 0; n < RANDOM_STROBES; n++) begin
			if (runLeft == 0 && ($random(seed) & 15) == 0) begin
				runLeft = 3 + ($random(seed) & 3);
			end
			if (runLeft > 0) begin
				x = PROBE_VALUE;
				runLeft--;
			end else begin
				lvl = $random(seed) & 3;
				jitter = ($random(seed) & 31) % 19 - 9;
				x = sample_t'(int'(LEVEL_CENTER[lvl]) + jitter);
			end
			strobeAndCheck(x);
		end
		reportTest("random stream");
	endtask

	initial begin
		seed = 27612;
		errorCount = 0;
		checkCount = 0;
		testErrors = 0;
		reset = 1'b1;
		samClkEn = 1'b0;
		xIn = '0;
		repeat (4) @(posedge sys_clk);
		reset <= 1'b0;
		testReset();
		testProbeImpulse();
		testLevelWindows();
		testHold();
		testRandomStream();
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
